// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module exe_stage_tb -o sim_exe_stage \
    && ./obj_dir/sim_exe_stage | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpu_ops_pkg::alu_op_t alu_op,
    input  logic [31:0]          src1,
    input  logic [31:0]          src2,
    output logic [31:0]          result,
    output logic                 overflow
);
    import cpu_ops_pkg::*;

    logic        is_sub;
    logic [31:0] adder_b;
    logic [32:0] adder_sum;
    logic        slt_bit;
    logic        sltu_bit;

    // One adder serves add, sub and both compares
    assign is_sub    = alu_op inside {ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU};
    assign adder_b   = is_sub ? ~src2 : src2;
    assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + 33'(is_sub);

    assign slt_bit  = (src1[31] & ~src2[31])
                    | (~(src1[31] ^ src2[31]) & adder_sum[31]);
    assign sltu_bit = ~adder_sum[32];  // Borrow out

    // Same-sign operands with a result of the other sign
    assign overflow = (src1[31] == adder_b[31]) && (adder_sum[31] != src1[31]);

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU: begin
                result = adder_sum[31:0];
            end
            ALU_SLT:  result = {31'b0, slt_bit};
            ALU_SLTU: result = {31'b0, sltu_bit};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src2 << src1[4:0];  // src1 carries the shift amount
            ALU_SRL:  result = src2 >> src1[4:0];
            ALU_SRA:  result = $signed(src2) >>> src1[4:0];
            ALU_LUI:  result = {src2[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

endmodule

// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_XLEN      32
`define CPU_REG_AW    5

// One quotient bit per iteration
`define CPU_DIV_STEPS 32

// kseg0/kseg1 addresses lose these bits
`define CPU_KSEG_MASK 32'hE000_0000

`endif

// File: source/cpu_exc_pkg.sv
package cpu_exc_pkg;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADES = 5'd5,  // Address error on store
        EXC_OV   = 5'd12
    } exc_code_t;

    // Earlier stage wins, then address error, then overflow
    function automatic exc_code_t exc_select(input exc_code_t upstream,
                                             input logic ades,
                                             input logic ov);
        if (upstream != EXC_NONE)
            return upstream;
        if (ades)
            return EXC_ADES;
        if (ov)
            return EXC_OV;
        return EXC_NONE;
    endfunction

endpackage

// File: source/cpu_ops_pkg.sv
package cpu_ops_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU, MD_MTHI, MD_MTLO
    } md_op_t;

    typedef enum logic [2:0] {
        SRC1_RS, SRC1_SA, SRC1_PC, SRC1_HI, SRC1_LO, SRC1_ZERO
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RT, SRC2_SIMM, SRC2_UIMM, SRC2_EIGHT
    } src2_sel_t;

    typedef enum logic [1:0] {
        ST_NONE, ST_SB, ST_SH, ST_SW
    } store_op_t;

    // Low half of an R-type word
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } rtype_field_t;

    typedef union packed {
        logic [15:0]  imm;
        rtype_field_t rtype;
    } imm_field_u;

endpackage

// File: source/divider.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module divider (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        start,
    input  logic        is_signed,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder,
    output logic        done,
    input  logic        ack
);
    localparam int CW = $clog2(`CPU_DIV_STEPS);

    logic          busy;
    logic [CW-1:0] count;
    logic [31:0]   quo_r;  // Dividend shifts out as quotient bits shift in
    logic [31:0]   rem_r;
    logic [31:0]   div_r;
    logic          quo_neg;
    logic          rem_neg;
    logic          div_zero;
    logic [31:0]   abs_dividend;
    logic [31:0]   abs_divisor;
    logic [32:0]   shifted;
    logic [33:0]   trial;

    assign abs_dividend = (is_signed && dividend[31]) ? -dividend : dividend;
    assign abs_divisor  = (is_signed && divisor[31]) ? -divisor : divisor;

    assign shifted = {rem_r, quo_r[31]};
    assign trial   = {1'b0, shifted} - {2'b0, div_r};  // Top bit is the borrow

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == CW'(`CPU_DIV_STEPS - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_r    <= abs_dividend;
            rem_r    <= '0;
            div_r    <= abs_divisor;
            quo_neg  <= is_signed && (dividend[31] ^ divisor[31]);
            rem_neg  <= is_signed && dividend[31];
            div_zero <= (divisor == '0);
        end else if (busy) begin
            if (!trial[33]) begin
                rem_r <= trial[31:0];
                quo_r <= {quo_r[30:0], 1'b1};
            end else begin
                rem_r <= shifted[31:0];  // Restore
                quo_r <= {quo_r[30:0], 1'b0};
            end
        end
    end

    // Sign fix-up on the way out
    assign quotient  = div_zero ? '1 : (quo_neg ? -quo_r : quo_r);
    assign remainder = rem_neg ? -rem_r : rem_r;

endmodule

// File: source/exe_stage.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module exe_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       in_valid,
    input  cpu_ops_pkg::alu_op_t       alu_op,
    input  cpu_ops_pkg::md_op_t        md_op,
    input  cpu_ops_pkg::src1_sel_t     src1_sel,
    input  cpu_ops_pkg::src2_sel_t     src2_sel,
    input  cpu_ops_pkg::store_op_t     store_op,
    input  logic                       load_op,
    input  logic                       ov_check,
    input  logic                       gr_we,
    input  logic [`CPU_REG_AW-1:0]     dest,
    input  cpu_ops_pkg::imm_field_u    imm,
    input  logic [`CPU_XLEN-1:0]       rs_value,
    input  logic [`CPU_XLEN-1:0]       rt_value,
    input  logic [`CPU_XLEN-1:0]       pc,
    input  cpu_exc_pkg::exc_code_t     in_exc_code,
    input  logic                       out_ready,
    output logic                       allowin,
    output logic                       out_valid,
    output logic [`CPU_XLEN-1:0]       out_result,
    output logic [`CPU_REG_AW-1:0]     out_dest,
    output logic                       out_gr_we,
    output logic                       out_load,
    output logic [`CPU_XLEN-1:0]       out_pc,
    output cpu_exc_pkg::exc_code_t     out_exc_code,
    output logic                       fwd_valid,
    output logic [`CPU_XLEN-1:0]       fwd_result,
    output logic                       data_sram_req,
    output logic                       data_sram_wr,
    output logic [3:0]                 data_sram_wen,
    output logic [`CPU_XLEN-1:0]       data_sram_addr,
    output logic [`CPU_XLEN-1:0]       data_sram_wdata
);
    import cpu_ops_pkg::*;
    import cpu_exc_pkg::*;

    logic                   es_valid;
    logic                   ready_go;
    logic                   leave;
    alu_op_t                alu_op_r;
    md_op_t                 md_op_r;
    src1_sel_t              src1_sel_r;
    src2_sel_t              src2_sel_r;
    store_op_t              store_op_r;
    logic                   load_op_r;
    logic                   ov_check_r;
    logic                   gr_we_r;
    logic [`CPU_REG_AW-1:0] dest_r;
    imm_field_u             imm_r;
    logic [`CPU_XLEN-1:0]   rs_r;
    logic [`CPU_XLEN-1:0]   rt_r;
    logic [`CPU_XLEN-1:0]   pc_r;
    exc_code_t              exc_r;
    logic [`CPU_XLEN-1:0]   hi;
    logic [`CPU_XLEN-1:0]   lo;
    logic [`CPU_XLEN-1:0]   src1;
    logic [`CPU_XLEN-1:0]   src2;
    logic [`CPU_XLEN-1:0]   alu_result;
    logic                   alu_ov;
    logic                   is_div;
    logic                   div_issued;
    logic                   div_start;
    logic                   div_done;
    logic [`CPU_XLEN-1:0]   div_quotient;
    logic [`CPU_XLEN-1:0]   div_remainder;
    logic                   mul_signed;
    logic [63:0]            product;
    logic [3:0]             st_wen;
    logic                   st_ades;
    logic                   is_store;
    exc_code_t              exc_code;
    logic                   no_exc;

    assign is_div    = (md_op_r == MD_DIV) || (md_op_r == MD_DIVU);
    assign ready_go  = !is_div || div_done;
    assign out_valid = es_valid && ready_go;
    assign allowin   = !es_valid || (ready_go && out_ready);
    assign leave     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush)
            es_valid <= 1'b0;
        else if (allowin)
            es_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            alu_op_r   <= alu_op;
            md_op_r    <= md_op;
            src1_sel_r <= src1_sel;
            src2_sel_r <= src2_sel;
            store_op_r <= store_op;
            load_op_r  <= load_op;
            ov_check_r <= ov_check;
            gr_we_r    <= gr_we;
            dest_r     <= dest;
            imm_r      <= imm;
            rs_r       <= rs_value;
            rt_r       <= rt_value;
            pc_r       <= pc;
            exc_r      <= in_exc_code;
        end
    end

    always_comb begin
        case (src1_sel_r)
            SRC1_SA:   src1 = {27'b0, imm_r.rtype.sa};
            SRC1_PC:   src1 = pc_r;
            SRC1_HI:   src1 = hi;
            SRC1_LO:   src1 = lo;
            SRC1_ZERO: src1 = '0;
            default:   src1 = rs_r;
        endcase
        case (src2_sel_r)
            SRC2_SIMM:  src2 = {{16{imm_r.imm[15]}}, imm_r.imm};
            SRC2_UIMM:  src2 = {16'b0, imm_r.imm};
            SRC2_EIGHT: src2 = 32'd8;  // Link address
            default:    src2 = rt_r;
        endcase
    end

    alu alu_inst (
        .alu_op   (alu_op_r),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (alu_ov)
    );

    // Divider runs once per held divide
    assign div_start = es_valid && is_div && !div_issued;

    always_ff @(posedge clk) begin
        if (reset || flush || leave)
            div_issued <= 1'b0;
        else if (div_start)
            div_issued <= 1'b1;
    end

    divider divider_inst (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (div_start),
        .is_signed (md_op_r == MD_DIV),
        .dividend  (rs_r),
        .divisor   (rt_r),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .done      (div_done),
        .ack       (leave)
    );

    // Sign-extended 64-bit operands give the low 64 bits right for both kinds
    assign mul_signed = (md_op_r == MD_MULT);
    assign product    = {{32{mul_signed & rs_r[31]}}, rs_r}
                      * {{32{mul_signed & rt_r[31]}}, rt_r};

    store_align store_align_inst (
        .store_op (store_op_r),
        .addr_low (alu_result[1:0]),
        .rt_value (rt_r),
        .wen      (st_wen),
        .wdata    (data_sram_wdata),
        .ades     (st_ades)
    );

    assign exc_code = exc_select(exc_r, st_ades, ov_check_r && alu_ov);
    assign no_exc   = (exc_code == EXC_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (leave && no_exc) begin
            case (md_op_r)
                MD_MULT, MD_MULTU: {hi, lo} <= product;
                MD_DIV, MD_DIVU: begin
                    hi <= div_remainder;
                    lo <= div_quotient;
                end
                MD_MTHI: hi <= rs_r;
                MD_MTLO: lo <= rs_r;
                default: ;
            endcase
        end
    end

    assign is_store = (store_op_r != ST_NONE);

    // Unmapped segments drop their top bits
    assign data_sram_addr = (alu_result[31:30] == 2'b10) ? (alu_result & ~`CPU_KSEG_MASK)
                                                          : alu_result;
    assign data_sram_req  = leave && (load_op_r || is_store) && no_exc;
    assign data_sram_wr   = is_store;
    assign data_sram_wen  = st_wen & {4{no_exc}};

    assign out_result   = alu_result;
    assign out_dest     = dest_r;
    assign out_gr_we    = gr_we_r;
    assign out_load     = load_op_r;
    assign out_pc       = pc_r;
    assign out_exc_code = exc_code;

    assign fwd_valid  = es_valid && gr_we_r && !load_op_r;
    assign fwd_result = alu_result;

endmodule

// File: source/store_align.sv
`timescale 1ns/10ps

module store_align (
    input  cpu_ops_pkg::store_op_t store_op,
    input  logic [1:0]             addr_low,
    input  logic [31:0]            rt_value,
    output logic [3:0]             wen,
    output logic [31:0]            wdata,
    output logic                   ades
);
    import cpu_ops_pkg::*;

    always_comb begin
        wen   = 4'b0000;
        wdata = rt_value;
        ades  = 1'b0;
        case (store_op)
            ST_SB: begin
                wdata = {4{rt_value[7:0]}};  // Byte in every lane
                wen   = 4'b0001 << addr_low;
            end
            ST_SH: begin
                wdata = {2{rt_value[15:0]}};
                if (addr_low[0])
                    ades = 1'b1;
                else
                    wen = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            ST_SW: begin
                if (addr_low != 2'b00)
                    ades = 1'b1;
                else
                    wen = 4'b1111;
            end
            default: begin
                wen = 4'b0000;  // Not a store
            end
        endcase
    end

endmodule

// File: src.f
+incdir+source
source/cpu_ops_pkg.sv
source/cpu_exc_pkg.sv
source/alu.sv
source/divider.sv
source/store_align.sv
source/exe_stage.sv
tests/exe_stage_properties.sv
tests/exe_stage_tb.sv

// File: tests/exe_stage_properties.sv
`timescale 1ns/10ps

module exe_stage_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input logic                   out_valid,
    input logic                   out_ready,
    input logic [31:0]            out_result,
    input logic [4:0]             out_dest,
    input logic [31:0]            out_pc,
    input cpu_exc_pkg::exc_code_t out_exc_code,
    input logic                   data_sram_req,
    input logic                   data_sram_wr,
    input logic [3:0]             data_sram_wen
);
    // A stalled result must wait unchanged for out_ready
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_result)
            && $stable(out_dest) && $stable(out_pc) && $stable(out_exc_code)
            && $stable(data_sram_wen))
        else $error("outputs changed while stalled");

    // Stores carry byte enables and loads carry none
    req_well_formed: assert property (@(posedge clk) disable iff (reset)
        data_sram_req |-> out_valid && out_ready
            && (data_sram_wr ? (data_sram_wen != 4'b0000) : (data_sram_wen == 4'b0000)))
        else $error("data_sram_req outside a leave or with wrong byte enables");

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else $error("out_valid high right after flush");

endmodule

bind exe_stage exe_stage_properties exe_stage_properties_inst (.*);

// File: tests/exe_stage_tb.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module exe_stage_tb;
    import cpu_ops_pkg::*;
    import cpu_exc_pkg::*;

    localparam int N_ALU   = 200;
    localparam int N_MD    = 60;
    localparam int N_ST    = 80;
    localparam int N_ADDR  = 60;
    localparam int N_INSTR = N_ALU + 3 * N_MD + N_ST + N_ADDR + 4;
    localparam int TIMEOUT = N_INSTR * (`CPU_DIV_STEPS + 8) * 2;

    typedef struct {
        logic [31:0] result;
        exc_code_t   exc;
        logic        mem;
        logic        store;
        logic        load;
        logic        gr_we;
        logic        req;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [4:0]  dest;
        logic [31:0] pc;
        logic [31:0] hi;
        logic [31:0] lo;
    } expect_t;

    logic clk, reset, flush, in_valid, load_op, ov_check, gr_we, out_ready;
    alu_op_t     alu_op;
    md_op_t      md_op;
    src1_sel_t   src1_sel;
    src2_sel_t   src2_sel;
    store_op_t   store_op;
    logic [4:0]  dest;
    imm_field_u  imm;
    logic [31:0] rs_value, rt_value, pc;
    exc_code_t   in_exc_code;
    logic        allowin, out_valid, out_gr_we, out_load, fwd_valid;
    logic [31:0] out_result, out_pc, fwd_result;
    logic [4:0]  out_dest;
    exc_code_t   out_exc_code;
    logic        data_sram_req, data_sram_wr;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr, data_sram_wdata;

    expect_t     expq[$];
    expect_t     e;
    logic [31:0] model_hi, model_lo;
    int          checks, errors, leaves, stalls, dropped;

    exe_stage exe_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        out_ready <= !reset && ($urandom_range(3) != 0);  // Low about a quarter of the time

    function automatic logic [31:0] rand_word();
        case ($urandom_range(7))
            0: return 32'h7fff_ffff;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h0;
            default: return $urandom;
        endcase
    endfunction

    // Reference model of one instruction from the driven inputs
    function automatic expect_t predict();
        expect_t     x;
        logic [31:0] s1, s2, r;
        longint      wide;
        logic        ov, ades;
        case (src1_sel)
            SRC1_SA:   s1 = {27'b0, imm.rtype.sa};
            SRC1_PC:   s1 = pc;
            SRC1_HI:   s1 = model_hi;
            SRC1_LO:   s1 = model_lo;
            SRC1_ZERO: s1 = 32'b0;
            default:   s1 = rs_value;
        endcase
        case (src2_sel)
            SRC2_SIMM:  s2 = 32'($signed(imm.imm));
            SRC2_UIMM:  s2 = {16'b0, imm.imm};
            SRC2_EIGHT: s2 = 32'd8;
            default:    s2 = rt_value;
        endcase
        wide = 0;
        case (alu_op)
            ALU_ADD, ALU_ADDU: begin
                r = s1 + s2;
                wide = longint'($signed(s1)) + longint'($signed(s2));
            end
            ALU_SUB, ALU_SUBU: begin
                r = s1 - s2;
                wide = longint'($signed(s1)) - longint'($signed(s2));
            end
            ALU_SLT:  r = {31'b0, $signed(s1) < $signed(s2)};
            ALU_SLTU: r = {31'b0, s1 < s2};
            ALU_AND:  r = s1 & s2;
            ALU_OR:   r = s1 | s2;
            ALU_XOR:  r = s1 ^ s2;
            ALU_NOR:  r = ~(s1 | s2);
            ALU_SLL:  r = s2 << s1[4:0];
            ALU_SRL:  r = s2 >> s1[4:0];
            ALU_SRA:  r = $signed(s2) >>> s1[4:0];
            ALU_LUI:  r = {s2[15:0], 16'b0};
            default:  r = 32'b0;
        endcase
        // Overflow when the exact sum does not fit in 32 bits
        ov = (alu_op inside {ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU})
            && (wide != longint'($signed(r)));
        ades = (store_op == ST_SH && r[0]) || (store_op == ST_SW && r[1:0] != 2'b00);
        if (in_exc_code != EXC_NONE)
            x.exc = in_exc_code;
        else if (ades)
            x.exc = EXC_ADES;
        else if (ov_check && ov)
            x.exc = EXC_OV;
        else
            x.exc = EXC_NONE;
        x.result = r;
        x.dest   = dest;
        x.pc     = pc;
        x.mem    = load_op || store_op != ST_NONE;
        x.store  = store_op != ST_NONE;
        x.load   = load_op;
        x.gr_we  = gr_we;
        x.req    = x.mem && x.exc == EXC_NONE;
        x.addr   = (r[31:29] == 3'b100 || r[31:29] == 3'b101) ? {3'b000, r[28:0]} : r;
        x.wen    = 4'b0000;
        x.wdata  = rt_value;
        case (store_op)
            ST_SB: begin
                x.wdata = {4{rt_value[7:0]}};
                x.wen   = 4'b0001 << r[1:0];
            end
            ST_SH: begin
                x.wdata = {2{rt_value[15:0]}};
                x.wen   = r[1] ? 4'b1100 : 4'b0011;
            end
            ST_SW: x.wen = 4'b1111;
            default: ;
        endcase
        if (x.exc != EXC_NONE)
            x.wen = 4'b0000;
        x.hi = model_hi;
        x.lo = model_lo;
        if (x.exc == EXC_NONE) begin
            case (md_op)
                MD_MULT:  {x.hi, x.lo} = longint'($signed(rs_value)) * longint'($signed(rt_value));
                MD_MULTU: {x.hi, x.lo} = {32'b0, rs_value} * {32'b0, rt_value};
                MD_DIV, MD_DIVU: begin
                    if (rt_value == 32'b0) begin
                        x.lo = 32'hffff_ffff;
                        x.hi = rs_value;
                    end else if (md_op == MD_DIV) begin
                        x.lo = 32'(longint'($signed(rs_value)) / longint'($signed(rt_value)));
                        x.hi = 32'(longint'($signed(rs_value)) % longint'($signed(rt_value)));
                    end else begin
                        x.lo = rs_value / rt_value;
                        x.hi = rs_value % rt_value;
                    end
                end
                MD_MTHI: x.hi = rs_value;
                MD_MTLO: x.lo = rs_value;
                default: ;
            endcase
        end
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Leaves handled before accepts half a cycle ahead of the edge
    always @(negedge clk) begin
        if (!reset) begin
            check("hi", exe_stage_inst.hi, model_hi);
            check("lo", exe_stage_inst.lo, model_lo);
            if (flush) begin
                dropped += expq.size();
                expq.delete();
            end else begin
                if (out_valid && !out_ready)
                    stalls++;
                if (out_valid && out_ready) begin
                    leaves++;
                    if (expq.size() == 0) begin
                        $display("instruction left the stage at %0t with none expected", $time);
                        errors++;
                    end else begin
                        e = expq.pop_front();
                        check("out_result", out_result, e.result);
                        check("out_exc_code", 32'(out_exc_code), 32'(e.exc));
                        check("out_dest", 32'(out_dest), 32'(e.dest));
                        check("out_pc", out_pc, e.pc);
                        check("out_gr_we", 32'(out_gr_we), 32'(e.gr_we));
                        check("out_load", 32'(out_load), 32'(e.load));
                        check("fwd_valid", 32'(fwd_valid), 32'(e.gr_we && !e.load));
                        if (e.gr_we && !e.load)
                            check("fwd_result", fwd_result, e.result);
                        check("data_sram_req", 32'(data_sram_req), 32'(e.req));
                        check("data_sram_wen", 32'(data_sram_wen), 32'(e.wen));
                        if (e.mem) begin
                            check("data_sram_addr", data_sram_addr, e.addr);
                            check("data_sram_wr", 32'(data_sram_wr), 32'(e.store));
                        end
                        if (e.req && e.store)
                            check("data_sram_wdata", data_sram_wdata, e.wdata);
                        model_hi = e.hi;
                        model_lo = e.lo;
                    end
                end
                if (in_valid && allowin)
                    expq.push_back(predict());
            end
        end
    end

    // Defaults for a new instruction; callers override fields on the same edge
    task automatic begin_instr();
        if ($urandom_range(7) == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid    <= 1'b1;
        alu_op      <= ALU_ADDU;
        md_op       <= MD_NONE;
        src1_sel    <= SRC1_RS;
        src2_sel    <= SRC2_RT;
        store_op    <= ST_NONE;
        load_op     <= 1'b0;
        ov_check    <= 1'b0;
        gr_we       <= 1'b1;
        dest        <= 5'($urandom);
        imm         <= 16'($urandom);
        rs_value    <= rand_word();
        rt_value    <= rand_word();
        pc          <= $urandom & 32'hffff_fffc;
        in_exc_code <= EXC_NONE;
    endtask

    task automatic wait_accept();
        do @(negedge clk); while (!allowin);
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (expq.size() != 0)
            @(negedge clk);
    endtask

    task automatic read_hilo();
        for (int i = 0; i < 2; i++) begin
            begin_instr();
            src1_sel <= (i == 0) ? SRC1_HI : SRC1_LO;
            alu_op   <= ALU_OR;
            rt_value <= 32'b0;
            wait_accept();
        end
    endtask

    task automatic report(input string name, input int errs0);
        $display("test %s finished with %0d errors", name, errors - errs0);
    endtask

    initial begin
        int      errs0;
        alu_op_t op;
        void'($urandom(32'h3cb5_abab));
        reset = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        alu_op = ALU_ADDU;
        md_op = MD_NONE;
        src1_sel = SRC1_RS;
        src2_sel = SRC2_RT;
        store_op = ST_NONE;
        load_op = 1'b0;
        ov_check = 1'b0;
        gr_we = 1'b0;
        dest = '0;
        imm = '0;
        rs_value = '0;
        rt_value = '0;
        pc = '0;
        in_exc_code = EXC_NONE;
        model_hi = '0;
        model_lo = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        errs0 = errors;
        repeat (N_ALU) begin
            begin_instr();
            op = alu_op_t'($urandom_range(13));
            alu_op   <= op;
            ov_check <= op inside {ALU_ADD, ALU_SUB};
            src1_sel <= src1_sel_t'($urandom_range(5));
            src2_sel <= src2_sel_t'($urandom_range(3));
            if ($urandom_range(15) == 0)
                in_exc_code <= EXC_OV;  // Raised upstream
            wait_accept();
        end
        drain();
        report("alu", errs0);

        errs0 = errors;
        repeat (N_MD) begin
            begin_instr();
            md_op <= md_op_t'($urandom_range(6, 1));
            gr_we <= 1'b0;
            if ($urandom_range(7) == 0)
                rt_value <= 32'b0;
            wait_accept();
            read_hilo();
        end
        drain();
        report("muldiv", errs0);

        errs0 = errors;
        repeat (N_ST) begin
            begin_instr();
            store_op <= store_op_t'($urandom_range(3, 1));
            src2_sel <= SRC2_SIMM;
            gr_we    <= 1'b0;
            wait_accept();
        end
        drain();
        report("store", errs0);

        errs0 = errors;
        repeat (N_ADDR) begin
            begin_instr();
            rs_value <= {3'($urandom), 27'($urandom), 2'b00};
            imm      <= {14'($urandom), 2'b00};
            src2_sel <= SRC2_SIMM;
            if ($urandom_range(1) == 1) begin
                load_op <= 1'b1;
            end else begin
                store_op <= ST_SW;
                gr_we    <= 1'b0;
            end
            wait_accept();
        end
        drain();
        report("addrmap", errs0);

        errs0 = errors;
        dropped = 0;
        begin_instr();
        md_op <= MD_DIV;
        gr_we <= 1'b0;
        wait_accept();
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        read_hilo();
        begin_instr();
        md_op <= MD_DIVU;
        gr_we <= 1'b0;
        wait_accept();
        drain();
        assert (dropped == 1) else begin
            $display("flush dropped %0d instructions instead of one", dropped);
            errors++;
        end
        report("flush", errs0);

        // Every issued instruction leaves once except the flushed divide
        errs0 = errors;
        assert (leaves == N_INSTR - 1) else begin
            $display("%0d instructions left the stage instead of %0d", leaves, N_INSTR - 1);
            errors++;
        end
        assert (stalls > 0) else begin
            $display("out_ready never held back a finished instruction");
            errors++;
        end
        report("backpressure", errs0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("watchdog expired after %0d cycles", TIMEOUT);
        $display("Checks failed");
        $finish;
    end

endmodule
